// File: project.f
+incdir+bench
hw/mci_pkg.sv
hw/mci_sync_bank.sv
hw/mci_rst_timer.sv
hw/mci_boot_fsm.sv
hw/mci_reset_ctrl.sv
hw/mci_boot_seqr.sv
bench/tb_mci_boot_seqr.sv

// File: Makefile
SRCS = $(filter-out +%,$(shell cat project.f)) bench/boot_model.svh

.PHONY: run check clean

obj_dir/Vtb_mci_boot_seqr: project.f $(SRCS)
	verilator --binary --top-module tb_mci_boot_seqr -f project.f -o Vtb_mci_boot_seqr

run: obj_dir/Vtb_mci_boot_seqr
	./obj_dir/Vtb_mci_boot_seqr | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

check: run
	grep -F 'errors' sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/boot_model.svh
`ifndef BOOT_MODEL_SVH
`define BOOT_MODEL_SVH

//////////////////////////////
// Reference model
//////////////////////////////

int                      error_count;
int                      check_count;
int                      timeout_count;
mci_pkg::mci_boot_ctrl_t exp_ctrl;
mci_pkg::mci_boot_upd_t  exp_upd;
int                      upd_count;
// Inputs the bench has already given since reset
logic                    fc_done_given;
logic                    lc_done_given;
logic                    cptra_go_given;

task automatic model_reset();
  exp_ctrl       = '0;
  exp_upd        = '0;
  upd_count      = 0;
  fc_done_given  = 1'b0;
  lc_done_given  = 1'b0;
  cptra_go_given = 1'b0;
endtask

// First update reset is the boot update, every later one is hitless
task automatic model_upd_reset();
  upd_count                    = upd_count + 1;
  exp_upd.fw_boot_upd_reset    = (upd_count == 1);
  exp_upd.fw_hitless_upd_reset = (upd_count > 1);
  exp_upd.mcu_reset_once       = 1'b1;
  exp_ctrl.mcu_rst_b           = 1'b0;
endtask

task automatic report_error(input string msg);
  error_count = error_count + 1;
  $display("ERROR @ %0t: %s", $time, msg);
endtask

task automatic report_timeout(input string what, input int limit);
  timeout_count = timeout_count + 1;
  $display("TIMEOUT @ %0t: %s did not happen within %0d cycles", $time, what, limit);
endtask

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_ctrl(input mci_pkg::mci_boot_ctrl_t exp, input string what);
  check_count = check_count + 1;
  if (obs_ctrl !== exp) begin
    report_error($sformatf("%s, ctrl %05b expected %05b", what, obs_ctrl, exp));
  end
endtask

task automatic check_upd(input mci_pkg::mci_boot_upd_t exp, input string what);
  check_count = check_count + 1;
  if (obs_upd !== exp) begin
    report_error($sformatf("%s, update flags %03b expected %03b", what, obs_upd, exp));
  end
endtask

task automatic check_state(input mci_pkg::mci_boot_fsm_state_e exp, input string what);
  check_count = check_count + 1;
  if (boot_fsm !== exp) begin
    report_error($sformatf("%s, state %s expected %s", what, boot_fsm.name(), exp.name()));
  end
endtask

// One clock step, with the ordering rules that hold on every cycle
task automatic tick();
  @(negedge clk);
  if ($isunknown({obs_ctrl, obs_upd, boot_fsm})) begin
    report_error("outputs not in a known state");
  end
  if (obs_ctrl.lc_init && !fc_done_given) begin
    report_error("lc_init raised before fc_opt_done");
  end
  if ((obs_ctrl.mcu_rst_b || obs_ctrl.cptra_rst_b) && !lc_done_given) begin
    report_error("reset released before lc_done");
  end
  if (obs_ctrl.cptra_rst_b && !cptra_go_given) begin
    report_error("cptra_rst_b released before caliptra_boot_go");
  end
endtask

//////////////////////////////
// Waits
//////////////////////////////

task automatic wait_ctrl(input int limit, input string what);
  int cycles = 0;
  while (obs_ctrl !== exp_ctrl && cycles < limit) begin
    tick();
    cycles = cycles + 1;
  end
  if (obs_ctrl !== exp_ctrl) begin
    report_timeout(what, limit);
  end
  check_ctrl(exp_ctrl, what);
endtask

task automatic wait_state(input mci_pkg::mci_boot_fsm_state_e target, input int limit,
                          input string what);
  int cycles = 0;
  while (boot_fsm !== target && cycles < limit) begin
    tick();
    cycles = cycles + 1;
  end
  if (boot_fsm !== target) begin
    report_timeout(what, limit);
  end
  check_state(target, what);
endtask

`endif

// File: bench/tb_mci_boot_seqr.sv
`timescale 1ns/1ps

module tb_mci_boot_seqr;

  localparam int RST_W          = 4;
  localparam int MIN_RST_CYCLES = 1 << RST_W;

  logic clk;
  logic mci_rst_b;
  logic fc_opt_done;
  logic lc_done;
  logic brkpoint;
  logic no_rom_config;
  logic caliptra_boot_go;
  logic bootfsm_go;
  logic mcu_rst_req;
  logic halt_ack;
  logic halt_status;
  logic fw_lock;
  logic mcu_rst_b;
  logic cptra_rst_b;
  logic fc_opt_init;
  logic lc_init;
  logic halt_req;
  logic fw_boot_upd;
  logic fw_hitless_upd;
  logic mcu_reset_once;
  integer                       seed;
  mci_pkg::mci_boot_fsm_state_e boot_fsm;
  mci_pkg::mci_boot_ctrl_t      obs_ctrl;
  mci_pkg::mci_boot_upd_t       obs_upd;

  mci_boot_seqr #(
    .MIN_MCU_RST_COUNTER_WIDTH (RST_W)
  ) dut (
    .clk                            (clk),
    .mci_rst_b                      (mci_rst_b),
    .fc_opt_done_i                  (fc_opt_done),
    .lc_done_i                      (lc_done),
    .mci_boot_seq_brkpoint_i        (brkpoint),
    .mcu_no_rom_config_i            (no_rom_config),
    .caliptra_boot_go_i             (caliptra_boot_go),
    .mci_bootfsm_go_i               (bootfsm_go),
    .mcu_rst_req_i                  (mcu_rst_req),
    .mcu_cpu_halt_ack_i             (halt_ack),
    .mcu_cpu_halt_status_i          (halt_status),
    .mcu_sram_fw_exec_region_lock_i (fw_lock),
    .mcu_rst_b_o                    (mcu_rst_b),
    .cptra_rst_b_o                  (cptra_rst_b),
    .fc_opt_init_o                  (fc_opt_init),
    .lc_init_o                      (lc_init),
    .mcu_cpu_halt_req_o             (halt_req),
    .fw_boot_upd_reset_o            (fw_boot_upd),
    .fw_hitless_upd_reset_o         (fw_hitless_upd),
    .mcu_reset_once_o               (mcu_reset_once),
    .boot_fsm_o                     (boot_fsm)
  );

  // Regroup the ports into the DUT's own structs for comparison
  always_comb begin
    obs_ctrl.mcu_rst_b            = mcu_rst_b;
    obs_ctrl.cptra_rst_b          = cptra_rst_b;
    obs_ctrl.fc_opt_init          = fc_opt_init;
    obs_ctrl.lc_init              = lc_init;
    obs_ctrl.mcu_cpu_halt_req     = halt_req;
    obs_upd.fw_boot_upd_reset     = fw_boot_upd;
    obs_upd.fw_hitless_upd_reset  = fw_hitless_upd;
    obs_upd.mcu_reset_once        = mcu_reset_once;
  end

  `include "boot_model.svh"

  always #20 clk = ~clk;

  function automatic int rand_between(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  task automatic hold_steady(input int n, input string what);
    repeat (n) begin
      tick();
      check_ctrl(exp_ctrl, what);
    end
  endtask

  task automatic apply_reset(input logic brk, input logic no_rom);
    tick();
    mci_rst_b        = 1'b0;
    fc_opt_done      = 1'b0;
    lc_done          = 1'b0;
    caliptra_boot_go = 1'b0;
    brkpoint         = brk;
    no_rom_config    = no_rom;
    model_reset();
    repeat (10) tick();
    check_ctrl(exp_ctrl, "controls in reset");
    check_upd(exp_upd, "update flags in reset");
    check_state(mci_pkg::BOOT_IDLE, "state in reset");
    mci_rst_b = 1'b1;
  endtask

  //////////////////////////////
  // Boot flow
  //////////////////////////////

  task automatic boot_flow(input logic brk, input logic no_rom);
    exp_ctrl.fc_opt_init = 1'b1;
    wait_ctrl(10, "fc_opt_init after reset");
    hold_steady(rand_between(0, 12), "waiting for fuse controller");
    fc_opt_done          = 1'b1;
    fc_done_given        = 1'b1;
    exp_ctrl.lc_init     = 1'b1;
    wait_ctrl(10, "lc_init after fc_opt_done");
    hold_steady(rand_between(0, 12), "waiting for lifecycle controller");
    lc_done       = 1'b1;
    lc_done_given = 1'b1;
    if (brk) begin
      wait_state(mci_pkg::BOOT_BREAKPOINT, 10, "breakpoint stop");
      repeat (rand_between(5, 30)) begin
        tick();
        check_state(mci_pkg::BOOT_BREAKPOINT, "held at breakpoint");
        check_ctrl(exp_ctrl, "resets held at breakpoint");
      end
      bootfsm_go = 1'b1;
      tick();
      bootfsm_go = 1'b0;
    end
    // With ROM the MCU comes out of reset ahead of Caliptra
    if (!no_rom) begin
      exp_ctrl.mcu_rst_b = 1'b1;
      wait_ctrl(10, "mcu_rst_b release with ROM");
    end
    wait_state(mci_pkg::BOOT_WAIT_CPTRA_GO, 10, "wait for caliptra_boot_go");
    hold_steady(rand_between(0, 12), "waiting for caliptra_boot_go");
    caliptra_boot_go     = 1'b1;
    cptra_go_given       = 1'b1;
    exp_ctrl.cptra_rst_b = 1'b1;
    wait_ctrl(10, "cptra_rst_b after caliptra_boot_go");
    wait_state(mci_pkg::BOOT_WAIT_MCU_RST_REQ, 10, "reset request wait after boot");
  endtask

  //////////////////////////////
  // Firmware update reset
  //////////////////////////////

  task automatic update_reset();
    int lock_delay;
    int need;
    int low_cycles = 0;
    int cycles = 0;
    hold_steady(rand_between(1, 10), "MCU running");
    mcu_rst_req                = 1'b1;
    exp_ctrl.mcu_cpu_halt_req  = 1'b1;
    wait_ctrl(10, "halt request after reset request");
    check_state(mci_pkg::BOOT_HALT_MCU, "halt state");
    mcu_rst_req = 1'b0;
    hold_steady(rand_between(0, 10), "halt request held until acknowledge");
    halt_ack                  = 1'b1;
    exp_ctrl.mcu_cpu_halt_req = 1'b0;
    wait_ctrl(10, "halt request drop after acknowledge");
    check_state(mci_pkg::BOOT_WAIT_MCU_HALTED, "waiting for halted status");
    halt_ack = 1'b0;
    hold_steady(rand_between(0, 10), "MCU reset held off until halted");
    halt_status = 1'b1;
    wait_state(mci_pkg::BOOT_RST_MCU, 10, "MCU reset after halted status");
    halt_status = 1'b0;
    model_upd_reset();
    // Registered outputs trail the state by one cycle
    tick();
    check_ctrl(exp_ctrl, "MCU reset asserted");
    check_upd(exp_upd, "update kind");
    lock_delay = rand_between(0, 2 * MIN_RST_CYCLES);
    need       = (lock_delay + 1 > MIN_RST_CYCLES) ? lock_delay + 1 : MIN_RST_CYCLES;
    while (!mcu_rst_b && cycles < 4 * MIN_RST_CYCLES + 10) begin
      low_cycles = low_cycles + 1;
      if (cycles == lock_delay) begin
        fw_lock = 1'b1;
      end
      tick();
      cycles = cycles + 1;
    end
    if (!mcu_rst_b) begin
      report_timeout("mcu_rst_b release after lock", 4 * MIN_RST_CYCLES + 10);
    end
    if (low_cycles < need) begin
      report_error($sformatf("mcu_rst_b low %0d cycles, at least %0d needed",
                             low_cycles, need));
    end
    fw_lock            = 1'b0;
    exp_ctrl.mcu_rst_b = 1'b1;
    check_ctrl(exp_ctrl, "MCU reset released");
    wait_state(mci_pkg::BOOT_WAIT_MCU_RST_REQ, 10, "return to reset request wait");
    check_upd(exp_upd, "update flags after release");
  endtask

  initial begin
    int   boot_idx;
    int   n_upd;
    logic brk;
    logic no_rom;
    seed             = 32'h72f68cd2;
    clk              = 1'b0;
    mci_rst_b        = 1'b0;
    fc_opt_done      = 1'b0;
    lc_done          = 1'b0;
    brkpoint         = 1'b0;
    no_rom_config    = 1'b0;
    caliptra_boot_go = 1'b0;
    bootfsm_go       = 1'b0;
    mcu_rst_req      = 1'b0;
    halt_ack         = 1'b0;
    halt_status      = 1'b0;
    fw_lock          = 1'b0;
    error_count      = 0;
    check_count      = 0;
    timeout_count    = 0;
    model_reset();
    for (boot_idx = 0; boot_idx < 4; boot_idx++) begin
      // Fixed strap mixes first, the last boot draws its straps
      case (boot_idx)
        0: {brk, no_rom} = 2'b00;
        1: {brk, no_rom} = 2'b11;
        2: {brk, no_rom} = 2'b10;
        default: begin
          brk    = (rand_between(0, 1) == 1);
          no_rom = (rand_between(0, 1) == 1);
        end
      endcase
      n_upd = rand_between(2, 3);
      $display("Boot %0d: breakpoint %0b, no ROM %0b, %0d update resets",
               boot_idx, brk, no_rom, n_upd);
      apply_reset(brk, no_rom);
      boot_flow(brk, no_rom);
      repeat (n_upd) update_reset();
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: hw/mci_boot_seqr.sv
`timescale 1ns/1ps

module mci_boot_seqr #(
  // Minimum MCU reset time is 2**MIN_MCU_RST_COUNTER_WIDTH cycles
  parameter int MIN_MCU_RST_COUNTER_WIDTH = 4
) (
  input  logic                         clk,
  input  logic                         mci_rst_b,
  // Asynchronous SoC, LCC and FC levels
  input  logic                         fc_opt_done_i,
  input  logic                         lc_done_i,
  input  logic                         mci_boot_seq_brkpoint_i,
  input  logic                         mcu_no_rom_config_i,
  // Synchronous controls
  input  logic                         caliptra_boot_go_i,
  input  logic                         mci_bootfsm_go_i,
  input  logic                         mcu_rst_req_i,
  input  logic                         mcu_cpu_halt_ack_i,
  input  logic                         mcu_cpu_halt_status_i,
  input  logic                         mcu_sram_fw_exec_region_lock_i,
  output logic                         mcu_rst_b_o,
  output logic                         cptra_rst_b_o,
  output logic                         fc_opt_init_o,
  output logic                         lc_init_o,
  output logic                         mcu_cpu_halt_req_o,
  output logic                         fw_boot_upd_reset_o,
  output logic                         fw_hitless_upd_reset_o,
  output logic                         mcu_reset_once_o,
  output mci_pkg::mci_boot_fsm_state_e boot_fsm_o
);

  mci_pkg::mci_boot_sync_t      sync;
  mci_pkg::mci_boot_fsm_state_e state;
  mci_pkg::mci_boot_fsm_state_e state_nxt;
  mci_pkg::mci_boot_ctrl_t      ctrl;
  mci_pkg::mci_boot_upd_t       upd;
  logic                         rst_time_elapsed;

  mci_sync_bank u_sync_bank (
    .clk             (clk),
    .mci_rst_b       (mci_rst_b),
    .fc_opt_done_i   (fc_opt_done_i),
    .lc_done_i       (lc_done_i),
    .brkpoint_i      (mci_boot_seq_brkpoint_i),
    .no_rom_config_i (mcu_no_rom_config_i),
    .sync_o          (sync)
  );

  mci_boot_fsm u_boot_fsm (
    .clk                            (clk),
    .mci_rst_b                      (mci_rst_b),
    .sync_i                         (sync),
    .caliptra_boot_go_i             (caliptra_boot_go_i),
    .mci_bootfsm_go_i               (mci_bootfsm_go_i),
    .mcu_rst_req_i                  (mcu_rst_req_i),
    .mcu_cpu_halt_ack_i             (mcu_cpu_halt_ack_i),
    .mcu_cpu_halt_status_i          (mcu_cpu_halt_status_i),
    .mcu_sram_fw_exec_region_lock_i (mcu_sram_fw_exec_region_lock_i),
    .rst_time_elapsed_i             (rst_time_elapsed),
    .state_o                        (state),
    .state_nxt_o                    (state_nxt)
  );

  mci_rst_timer #(
    .MIN_MCU_RST_COUNTER_WIDTH (MIN_MCU_RST_COUNTER_WIDTH)
  ) u_rst_timer (
    .clk         (clk),
    .mci_rst_b   (mci_rst_b),
    .state_i     (state),
    .state_nxt_i (state_nxt),
    .elapsed_o   (rst_time_elapsed)
  );

  mci_reset_ctrl u_reset_ctrl (
    .clk                   (clk),
    .mci_rst_b             (mci_rst_b),
    .state_i               (state),
    .state_nxt_i           (state_nxt),
    .mcu_cpu_halt_status_i (mcu_cpu_halt_status_i),
    .ctrl_o                (ctrl),
    .upd_o                 (upd)
  );

  //////////////////////////////
  // Port unpacking
  //////////////////////////////

  assign mcu_rst_b_o            = ctrl.mcu_rst_b;
  assign cptra_rst_b_o          = ctrl.cptra_rst_b;
  assign fc_opt_init_o          = ctrl.fc_opt_init;
  assign lc_init_o              = ctrl.lc_init;
  assign mcu_cpu_halt_req_o     = ctrl.mcu_cpu_halt_req;
  assign fw_boot_upd_reset_o    = upd.fw_boot_upd_reset;
  assign fw_hitless_upd_reset_o = upd.fw_hitless_upd_reset;
  assign mcu_reset_once_o       = upd.mcu_reset_once;
  assign boot_fsm_o             = state;

endmodule

// File: hw/mci_reset_ctrl.sv
`timescale 1ns/1ps

module mci_reset_ctrl (
  input  logic                         clk,
  input  logic                         mci_rst_b,
  input  mci_pkg::mci_boot_fsm_state_e state_i,
  input  mci_pkg::mci_boot_fsm_state_e state_nxt_i,
  input  logic                         mcu_cpu_halt_status_i,
  output mci_pkg::mci_boot_ctrl_t      ctrl_o,
  output mci_pkg::mci_boot_upd_t       upd_o
);

  mci_pkg::mci_boot_ctrl_t ctrl_q;
  mci_pkg::mci_boot_ctrl_t ctrl_nxt;
  mci_pkg::mci_boot_upd_t  upd_q;
  mci_pkg::mci_boot_upd_t  upd_nxt;
  logic                    upd_rst_start;

  // MCU is halted and the FSM commits to the update reset
  assign upd_rst_start = (state_i == mci_pkg::BOOT_WAIT_MCU_HALTED) &&
                         (state_nxt_i == mci_pkg::BOOT_RST_MCU) &&
                         mcu_cpu_halt_status_i;

  //////////////////////////////
  // Control decode
  //////////////////////////////

  always_comb begin
    ctrl_nxt = ctrl_q;
    // Init levels are set once and never drop
    ctrl_nxt.fc_opt_init = ctrl_q.fc_opt_init | (state_i == mci_pkg::BOOT_OTP_FC);
    ctrl_nxt.lc_init     = ctrl_q.lc_init | (state_i == mci_pkg::BOOT_LCC);
    if (state_i == mci_pkg::BOOT_MCU) begin
      ctrl_nxt.mcu_rst_b = 1'b1;
    end else if (state_i == mci_pkg::BOOT_RST_MCU) begin
      ctrl_nxt.mcu_rst_b = 1'b0;
    end
    ctrl_nxt.cptra_rst_b = ctrl_q.cptra_rst_b | (state_i == mci_pkg::BOOT_CPTRA);
    // Halt request is a plain level, re-evaluated every cycle
    ctrl_nxt.mcu_cpu_halt_req = (state_i == mci_pkg::BOOT_HALT_MCU);
  end

  //////////////////////////////
  // Update history
  //////////////////////////////

  always_comb begin
    upd_nxt = upd_q;
    if (upd_rst_start) begin
      // First reset is the boot update, the rest are hitless
      upd_nxt.fw_boot_upd_reset    = !upd_q.mcu_reset_once;
      upd_nxt.fw_hitless_upd_reset = upd_q.mcu_reset_once;
    end
    if (state_i == mci_pkg::BOOT_RST_MCU) begin
      upd_nxt.mcu_reset_once = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      ctrl_q <= '0;
      upd_q  <= '0;
    end else begin
      ctrl_q <= ctrl_nxt;
      upd_q  <= upd_nxt;
    end
  end

  assign ctrl_o = ctrl_q;
  assign upd_o  = upd_q;

endmodule

// File: hw/mci_boot_fsm.sv
`timescale 1ns/1ps

module mci_boot_fsm (
  input  logic                         clk,
  input  logic                         mci_rst_b,
  input  mci_pkg::mci_boot_sync_t      sync_i,
  input  logic                         caliptra_boot_go_i,
  input  logic                         mci_bootfsm_go_i,
  input  logic                         mcu_rst_req_i,
  input  logic                         mcu_cpu_halt_ack_i,
  input  logic                         mcu_cpu_halt_status_i,
  input  logic                         mcu_sram_fw_exec_region_lock_i,
  input  logic                         rst_time_elapsed_i,
  output mci_pkg::mci_boot_fsm_state_e state_o,
  output mci_pkg::mci_boot_fsm_state_e state_nxt_o
);

  mci_pkg::mci_boot_fsm_state_e state_q;
  mci_pkg::mci_boot_fsm_state_e state_nxt;
  mci_pkg::mci_boot_fsm_state_e state_prev_q;

  //////////////////////////////
  // Next-state logic
  //////////////////////////////

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      mci_pkg::BOOT_IDLE: begin
        // Only reachable through reset, so move on right away
        state_nxt = mci_pkg::BOOT_OTP_FC;
      end

      mci_pkg::BOOT_OTP_FC: begin
        if (sync_i.fc_opt_done) begin
          state_nxt = mci_pkg::BOOT_LCC;
        end
      end

      mci_pkg::BOOT_LCC: begin
        if (sync_i.lc_done) begin
          state_nxt = mci_pkg::BOOT_BREAKPOINT_CHECK;
        end
      end

      mci_pkg::BOOT_BREAKPOINT_CHECK: begin
        // Breakpoint strap wins over the boot flow strap
        if (sync_i.brkpoint) begin
          state_nxt = mci_pkg::BOOT_BREAKPOINT;
        end else if (sync_i.no_rom_config) begin
          state_nxt = mci_pkg::BOOT_WAIT_CPTRA_GO;
        end else begin
          state_nxt = mci_pkg::BOOT_MCU;
        end
      end

      mci_pkg::BOOT_BREAKPOINT: begin
        // Parked here until the debugger lets the sequence go
        if (mci_bootfsm_go_i) begin
          if (sync_i.no_rom_config) begin
            state_nxt = mci_pkg::BOOT_WAIT_CPTRA_GO;
          end else begin
            state_nxt = mci_pkg::BOOT_MCU;
          end
        end
      end

      mci_pkg::BOOT_MCU: begin
        // Back from a firmware update reset, skip the Caliptra release
        if (state_prev_q == mci_pkg::BOOT_RST_MCU) begin
          state_nxt = mci_pkg::BOOT_WAIT_MCU_RST_REQ;
        end else begin
          state_nxt = mci_pkg::BOOT_WAIT_CPTRA_GO;
        end
      end

      mci_pkg::BOOT_WAIT_CPTRA_GO: begin
        if (caliptra_boot_go_i) begin
          state_nxt = mci_pkg::BOOT_CPTRA;
        end
      end

      mci_pkg::BOOT_CPTRA: begin
        state_nxt = mci_pkg::BOOT_WAIT_MCU_RST_REQ;
      end

      //////////////////////////////
      // Firmware update loop
      //////////////////////////////

      mci_pkg::BOOT_WAIT_MCU_RST_REQ: begin
        if (mcu_rst_req_i) begin
          state_nxt = mci_pkg::BOOT_HALT_MCU;
        end
      end

      mci_pkg::BOOT_HALT_MCU: begin
        if (mcu_cpu_halt_ack_i) begin
          state_nxt = mci_pkg::BOOT_WAIT_MCU_HALTED;
        end
      end

      mci_pkg::BOOT_WAIT_MCU_HALTED: begin
        if (mcu_cpu_halt_status_i) begin
          state_nxt = mci_pkg::BOOT_RST_MCU;
        end
      end

      mci_pkg::BOOT_RST_MCU: begin
        // Minimum reset time served and the new image is locked in SRAM
        if (rst_time_elapsed_i && mcu_sram_fw_exec_region_lock_i) begin
          state_nxt = mci_pkg::BOOT_MCU;
        end
      end

      default: begin
        // Illegal encoding, stuck here until reset
        state_nxt = mci_pkg::BOOT_UNKNOWN;
      end
    endcase
  end

  //////////////////////////////
  // State registers
  //////////////////////////////

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      state_q <= mci_pkg::BOOT_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  // Remember where the FSM came from on every change
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      state_prev_q <= mci_pkg::BOOT_IDLE;
    end else if (state_nxt != state_q) begin
      state_prev_q <= state_q;
    end
  end

  assign state_o     = state_q;
  assign state_nxt_o = state_nxt;

endmodule

// File: hw/mci_rst_timer.sv
`timescale 1ns/1ps

module mci_rst_timer #(
  parameter int MIN_MCU_RST_COUNTER_WIDTH = 4
) (
  input  logic                         clk,
  input  logic                         mci_rst_b,
  input  mci_pkg::mci_boot_fsm_state_e state_i,
  input  mci_pkg::mci_boot_fsm_state_e state_nxt_i,
  output logic                         elapsed_o
);

  logic [MIN_MCU_RST_COUNTER_WIDTH-1:0] count_q;
  logic [MIN_MCU_RST_COUNTER_WIDTH-1:0] count_nxt;
  logic                                 elapsed_q;
  logic                                 elapsed_nxt;
  logic                                 rst_entry;
  logic                                 in_rst;

  assign rst_entry = (state_nxt_i == mci_pkg::BOOT_RST_MCU) &&
                     (state_i != mci_pkg::BOOT_RST_MCU);
  assign in_rst    = (state_i == mci_pkg::BOOT_RST_MCU);

  always_comb begin
    count_nxt   = count_q;
    elapsed_nxt = elapsed_q;
    // Fresh start on every entry into MCU reset
    if (rst_entry) begin
      count_nxt   = '0;
      elapsed_nxt = 1'b0;
    end else if (in_rst && (count_q != '1)) begin
      count_nxt = count_q + 1'b1;
    end else if (in_rst) begin
      // Counter saturated, flag stays set until the next entry
      elapsed_nxt = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      count_q   <= '0;
      elapsed_q <= 1'b0;
    end else begin
      count_q   <= count_nxt;
      elapsed_q <= elapsed_nxt;
    end
  end

  assign elapsed_o = elapsed_q;

endmodule

// File: hw/mci_sync_bank.sv
`timescale 1ns/1ps

module mci_sync_bank (
  input  logic                    clk,
  input  logic                    mci_rst_b,
  input  logic                    fc_opt_done_i,
  input  logic                    lc_done_i,
  input  logic                    brkpoint_i,
  input  logic                    no_rom_config_i,
  output mci_pkg::mci_boot_sync_t sync_o
);

  mci_pkg::mci_boot_sync_t async_in;
  mci_pkg::mci_boot_sync_t meta_q;
  mci_pkg::mci_boot_sync_t sync_q;

  // Group the raw inputs so both stages share one layout
  always_comb begin
    async_in.fc_opt_done   = fc_opt_done_i;
    async_in.lc_done       = lc_done_i;
    async_in.brkpoint      = brkpoint_i;
    async_in.no_rom_config = no_rom_config_i;
  end

  // First stage may go metastable, second stage settles it
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= async_in;
      sync_q <= meta_q;
    end
  end

  assign sync_o = sync_q;

endmodule

// File: hw/mci_pkg.sv
package mci_pkg;

  //////////////////////////////
  // Boot sequencer state
  //////////////////////////////

  typedef enum logic [3:0] {
    BOOT_IDLE             = 4'h0,
    BOOT_OTP_FC           = 4'h1,
    BOOT_LCC              = 4'h2,
    BOOT_BREAKPOINT_CHECK = 4'h3,
    BOOT_BREAKPOINT       = 4'h4,
    BOOT_MCU              = 4'h5,
    BOOT_WAIT_CPTRA_GO    = 4'h6,
    BOOT_CPTRA            = 4'h7,
    BOOT_WAIT_MCU_RST_REQ = 4'h8,
    BOOT_HALT_MCU         = 4'h9,
    BOOT_WAIT_MCU_HALTED  = 4'hA,
    BOOT_RST_MCU          = 4'hB,
    // Landing state for any illegal encoding
    BOOT_UNKNOWN          = 4'hF
  } mci_boot_fsm_state_e;

  //////////////////////////////
  // Signal groups
  //////////////////////////////

  // Inputs after the two-flop synchronizers
  typedef struct packed {
    logic fc_opt_done;
    logic lc_done;
    logic brkpoint;
    logic no_rom_config;
  } mci_boot_sync_t;

  // Reset, init and halt controls, all active levels
  typedef struct packed {
    logic mcu_rst_b;
    logic cptra_rst_b;
    logic fc_opt_init;
    logic lc_init;
    logic mcu_cpu_halt_req;
  } mci_boot_ctrl_t;

  // Firmware update status
  typedef struct packed {
    logic fw_boot_upd_reset;
    logic fw_hitless_upd_reset;
    logic mcu_reset_once;
  } mci_boot_upd_t;

endpackage
